// File: Makefile
# Verilator flow for the router ingress aggregator

TOP = router_ingress_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		--top-module router_ingress -f router_ingress.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f router_ingress.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/ing_word_if.sv
// Packed word stream between ingress stages
// Carries data with byte keep, end of packet and a valid/ready handshake
`default_nettype none

interface ing_word_if;

    logic [ingress_pkg::word_bits-1:0]  data;
    // One bit per byte lane, lane 0 first
    logic [ingress_pkg::word_bytes-1:0] keep;
    logic                               last;
    logic                               valid;
    logic                               ready;

    // Producer side
    modport src (
        output data,
        output keep,
        output last,
        output valid,
        input  ready
    );

    // Consumer side
    modport snk (
        input  data,
        input  keep,
        input  last,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// File: hw/ingress_arbiter.sv
// Ingress round-robin merge
// Whole packets from the port FIFOs onto one bus, tagged with their source port
`default_nettype none

module ingress_arbiter (
    input  logic                                   core_clk_ifc,
    input  logic                                   reset,
    ing_word_if.snk                                ports [ingress_pkg::num_ports],
    output logic [ingress_pkg::word_bits-1:0]      out_data,
    output logic [ingress_pkg::word_bytes-1:0]     out_keep,
    output logic                                   out_last,
    output logic                                   out_valid,
    input  logic                                   out_ready,
    output logic [ingress_pkg::port_idx_bits-1:0]  out_port
);

    logic [ingress_pkg::num_ports-1:0]  valid_vec;
    logic [ingress_pkg::word_bits-1:0]  data_arr [ingress_pkg::num_ports];
    logic [ingress_pkg::word_bytes-1:0] keep_arr [ingress_pkg::num_ports];
    logic [ingress_pkg::num_ports-1:0]  last_vec;

    logic [ingress_pkg::port_idx_bits-1:0] grant_q;
    logic [ingress_pkg::port_idx_bits-1:0] rr_ptr;
    logic [ingress_pkg::port_idx_bits-1:0] pick;
    logic [ingress_pkg::port_idx_bits-1:0] sel;
    logic [ingress_pkg::port_idx_bits-1:0] rr_next;
    logic                                  busy;

    ////////////////////////////////////////////////////////////////////////////
    // Flatten the port streams so they can be indexed by grant

    for (genvar i = 0; i < ingress_pkg::num_ports; i++) begin : g_port
        assign valid_vec[i] = ports[i].valid;
        assign data_arr[i]  = ports[i].data;
        assign keep_arr[i]  = ports[i].keep;
        assign last_vec[i]  = ports[i].last;
        // Only the selected FIFO sees the output ready
        assign ports[i].ready = out_ready && (sel == (ingress_pkg::port_idx_bits)'(i));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Round-robin choice, starting the search at rr_ptr

    always_comb begin
        int  idx;
        logic found;
        pick  = rr_ptr;
        found = 1'b0;
        for (int k = 0; k < ingress_pkg::num_ports; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= ingress_pkg::num_ports) begin
                idx = idx - ingress_pkg::num_ports;
            end
            if (!found && valid_vec[idx]) begin
                pick  = (ingress_pkg::port_idx_bits)'(idx);
                found = 1'b1;
            end
        end
    end

    // Locked grant inside a packet, fresh choice between packets
    assign sel = busy ? grant_q : pick;

    assign rr_next = (sel == (ingress_pkg::port_idx_bits)'(ingress_pkg::num_ports - 1)) ?
                     '0 : sel + 1'b1;

    assign out_valid = busy ? valid_vec[grant_q] : (|valid_vec);
    assign out_data  = data_arr[sel];
    assign out_keep  = keep_arr[sel];
    assign out_last  = last_vec[sel];
    assign out_port  = sel;

    // Grant locks as soon as a word is offered so a stalled output stays stable
    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            busy    <= 1'b0;
            grant_q <= '0;
            rr_ptr  <= '0;
        end else if (out_valid && out_ready && out_last) begin
            busy   <= 1'b0;
            rr_ptr <= rr_next;
        end else if (!busy && (|valid_vec)) begin
            busy    <= 1'b1;
            grant_q <= pick;
        end
    end

endmodule

`default_nettype wire

// File: hw/ingress_pkg.sv
// Router ingress aggregator shared sizes
// Port count, converged word geometry, buffer depth and counter width
`default_nettype none

package ingress_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Ports

    // Byte-wide physical ingress ports
    localparam int num_ports     = 3;
    // Wide enough to tag any port on the converged bus
    localparam int port_idx_bits = 2;

    ////////////////////////////////////////////////////////////////////////////
    // Converged word

    localparam int word_bytes = 4;
    localparam int word_bits  = word_bytes * 8;

    ////////////////////////////////////////////////////////////////////////////
    // Buffering and statistics

    // Words per port FIFO, kept a power of two
    localparam int fifo_depth     = 8;
    localparam int fifo_addr_bits = 3;

    localparam int cnt_bits = 16;

endpackage

`default_nettype wire

// File: hw/port_packer.sv
// Ingress port packer
// Packs a byte stream into keep-masked words, drops disabled packets, counts frames
`default_nettype none

module port_packer (
    input  logic                              core_clk_ifc,
    input  logic                              reset,
    input  logic [7:0]                        in_data,
    input  logic                              in_valid,
    input  logic                              in_last,
    output logic                              in_ready,
    input  logic                              enable,
    input  logic                              cnt_clear,
    output logic [ingress_pkg::cnt_bits-1:0]  frame_cnt,
    ing_word_if.src                           words
);

    ////////////////////////////////////////////////////////////////////////////
    // State

    logic [ingress_pkg::word_bits-1:0]      word_data;
    logic [ingress_pkg::word_bytes-1:0]     word_keep;
    logic                                   word_last;
    logic                                   word_valid;

    // Lane of the next byte within the word
    logic [$clog2(ingress_pkg::word_bytes)-1:0] byte_pos;
    // Set between the first and last byte of a packet
    logic                                   in_pkt;
    // Current packet is being discarded
    logic                                   drop_pkt;

    logic                                   drop_now;
    logic                                   byte_fire;
    logic                                   word_done;
    logic [ingress_pkg::word_bytes-1:0]     keep_now;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake

    // Enable only matters at the first byte of a packet
    assign drop_now = in_pkt ? drop_pkt : !enable;

    // Dropped bytes never touch the word register, so they are always taken
    assign in_ready  = drop_now || !word_valid || words.ready;
    assign byte_fire = in_valid && in_ready;

    // Word complete on the top lane (word_bytes is a power of two) or at end of packet
    assign word_done = byte_fire && !drop_now && ((&byte_pos) || in_last);

    // Lanes up to and including the current one
    always_comb begin
        for (int b = 0; b < ingress_pkg::word_bytes; b++) begin
            keep_now[b] = (b <= int'(byte_pos));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            word_valid <= 1'b0;
            byte_pos   <= '0;
            in_pkt     <= 1'b0;
            drop_pkt   <= 1'b0;
        end else begin
            if (word_valid && words.ready) begin
                word_valid <= 1'b0;
            end
            if (word_done) begin
                word_valid <= 1'b1;
            end
            if (byte_fire) begin
                in_pkt <= !in_last;
                if (!in_pkt) begin
                    drop_pkt <= !enable;
                end
                if (!drop_now) begin
                    byte_pos <= in_last ? '0 : byte_pos + 1'b1;
                end
            end
        end
    end

    // Word payload, upper lanes cleared at the start of every word
    always_ff @(posedge core_clk_ifc) begin
        if (byte_fire && !drop_now) begin
            if (byte_pos == '0) begin
                word_data <= {{(ingress_pkg::word_bits - 8){1'b0}}, in_data};
            end else begin
                word_data[8*byte_pos +: 8] <= in_data;
            end
        end
        if (word_done) begin
            word_keep <= keep_now;
            word_last <= in_last;
        end
    end

    assign words.data  = word_data;
    assign words.keep  = word_keep;
    assign words.last  = word_last;
    assign words.valid = word_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Frame counter

    always_ff @(posedge core_clk_ifc) begin
        if (reset || cnt_clear) begin
            frame_cnt <= '0;
        end else if (byte_fire && in_last && !drop_now) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/router_ingress.sv
// Router ingress aggregator top
// Byte ports packed, buffered and merged onto one tagged 32-bit bus
`default_nettype none

module router_ingress (
    input  logic                                    core_clk_ifc,
    input  logic                                    reset,

    // Byte-wide ingress ports
    input  logic [7:0]                              in_data [ingress_pkg::num_ports],
    input  logic [ingress_pkg::num_ports-1:0]       in_valid,
    input  logic [ingress_pkg::num_ports-1:0]       in_last,
    output logic [ingress_pkg::num_ports-1:0]       in_ready,

    // Per-port control and statistics
    input  logic [ingress_pkg::num_ports-1:0]       port_enable,
    input  logic [ingress_pkg::num_ports-1:0]       cnt_clear,
    output logic [ingress_pkg::cnt_bits-1:0]        frame_cnt [ingress_pkg::num_ports],

    // Converged bus
    output logic [ingress_pkg::word_bits-1:0]       out_data,
    output logic [ingress_pkg::word_bytes-1:0]      out_keep,
    output logic                                    out_last,
    output logic                                    out_valid,
    input  logic                                    out_ready,
    output logic [ingress_pkg::port_idx_bits-1:0]   out_port
);

    ////////////////////////////////////////////////////////////////////////////
    // Word streams, packer to FIFO and FIFO to arbiter

    ing_word_if pack_words [ingress_pkg::num_ports] ();
    ing_word_if fifo_words [ingress_pkg::num_ports] ();

    ////////////////////////////////////////////////////////////////////////////
    // Per-port path

    for (genvar i = 0; i < ingress_pkg::num_ports; i++) begin : g_port
        port_packer u_packer (
            .core_clk_ifc (core_clk_ifc),
            .reset        (reset),
            .in_data      (in_data[i]),
            .in_valid     (in_valid[i]),
            .in_last      (in_last[i]),
            .in_ready     (in_ready[i]),
            .enable       (port_enable[i]),
            .cnt_clear    (cnt_clear[i]),
            .frame_cnt    (frame_cnt[i]),
            .words        (pack_words[i])
        );

        word_fifo u_fifo (
            .core_clk_ifc (core_clk_ifc),
            .reset        (reset),
            .wr           (pack_words[i]),
            .rd           (fifo_words[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Merge

    ingress_arbiter u_arbiter (
        .core_clk_ifc (core_clk_ifc),
        .reset        (reset),
        .ports        (fifo_words),
        .out_data     (out_data),
        .out_keep     (out_keep),
        .out_last     (out_last),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_port     (out_port)
    );

endmodule

`default_nettype wire

// File: hw/word_fifo.sv
// Per-port word FIFO
// Buffers packed words and pushes back-pressure upstream when full
`default_nettype none

module word_fifo (
    input  logic     core_clk_ifc,
    input  logic     reset,
    ing_word_if.snk  wr,
    ing_word_if.src  rd
);

    logic [ingress_pkg::word_bits-1:0]  mem_data [ingress_pkg::fifo_depth];
    logic [ingress_pkg::word_bytes-1:0] mem_keep [ingress_pkg::fifo_depth];
    logic                               mem_last [ingress_pkg::fifo_depth];

    logic [ingress_pkg::fifo_addr_bits-1:0] wr_ptr;
    logic [ingress_pkg::fifo_addr_bits-1:0] rd_ptr;
    // One extra bit so a full FIFO is distinguishable from an empty one
    logic [ingress_pkg::fifo_addr_bits:0]   count;

    logic wr_fire;
    logic rd_fire;

    assign wr.ready = !count[ingress_pkg::fifo_addr_bits];
    assign rd.valid = (count != '0);

    assign wr_fire = wr.valid && wr.ready;
    assign rd_fire = rd.valid && rd.ready;

    // Head of queue drives the read side directly
    assign rd.data = mem_data[rd_ptr];
    assign rd.keep = mem_keep[rd_ptr];
    assign rd.last = mem_last[rd_ptr];

    always_ff @(posedge core_clk_ifc) begin
        if (wr_fire) begin
            mem_data[wr_ptr] <= wr.data;
            mem_keep[wr_ptr] <= wr.keep;
            mem_last[wr_ptr] <= wr.last;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves occupancy unchanged
            if (wr_fire && !rd_fire) begin
                count <= count + 1'b1;
            end else if (rd_fire && !wr_fire) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: router_ingress.f
hw/ingress_pkg.sv
hw/ing_word_if.sv
hw/port_packer.sv
hw/word_fifo.sv
hw/ingress_arbiter.sv
hw/router_ingress.sv
verif/router_ingress_assertions.sv
verif/router_ingress_tb.sv

// File: verif/router_ingress_assertions.sv
// Converged bus protocol checks for the router ingress aggregator
`default_nettype none

module router_ingress_assertions (
    input logic                                   core_clk_ifc,
    input logic                                   reset,
    input logic [ingress_pkg::word_bits-1:0]      out_data,
    input logic [ingress_pkg::word_bytes-1:0]     out_keep,
    input logic                                   out_last,
    input logic                                   out_valid,
    input logic                                   out_ready,
    input logic [ingress_pkg::port_idx_bits-1:0]  out_port
);

    timeunit 1ns;
    timeprecision 1ps;

    // A stalled word holds until it is taken
    a_stall_hold: assert property (@(posedge core_clk_ifc) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_keep)
            && $stable(out_last) && $stable(out_port)))
        else $error("converged bus changed while stalled");

    // Partial keep only on the closing word of a packet
    a_keep_full: assert property (@(posedge core_clk_ifc) disable iff (reset)
        (out_valid && !out_last) |-> (out_keep == '1))
        else $error("partial keep on a word that is not last");

    a_keep_nonzero: assert property (@(posedge core_clk_ifc) disable iff (reset)
        out_valid |-> (out_keep != '0))
        else $error("valid word with empty keep");

    a_reset_idle: assert property (@(posedge core_clk_ifc)
        reset |=> !out_valid)
        else $error("output valid right after a reset edge");

endmodule

`default_nettype wire

// File: verif/router_ingress_tb.sv
// Router ingress testbench
// Table-driven packets on the byte ports checked word by word on the converged bus
`default_nettype none

module router_ingress_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_rows = 13;
    // Rows from here on run with random out_ready
    localparam int bp_first = 9;

    typedef struct packed {
        logic [7:0]                         row;
        logic                               last;
        logic [ingress_pkg::word_bytes-1:0] keep;
        logic [ingress_pkg::word_bits-1:0]  data;
    } exp_word_t;

    logic                                   core_clk_ifc;
    logic                                   reset;
    logic [7:0]                             in_data [ingress_pkg::num_ports];
    logic [ingress_pkg::num_ports-1:0]      in_valid;
    logic [ingress_pkg::num_ports-1:0]      in_last;
    logic [ingress_pkg::num_ports-1:0]      in_ready;
    logic [ingress_pkg::num_ports-1:0]      port_enable;
    logic [ingress_pkg::num_ports-1:0]      cnt_clear;
    logic [ingress_pkg::cnt_bits-1:0]       frame_cnt [ingress_pkg::num_ports];
    logic [ingress_pkg::word_bits-1:0]      out_data;
    logic [ingress_pkg::word_bytes-1:0]     out_keep;
    logic                                   out_last;
    logic                                   out_valid;
    logic                                   out_ready;
    logic [ingress_pkg::port_idx_bits-1:0]  out_port;

    // Stimulus table
    string row_name [num_rows];
    int    row_port [num_rows];
    int    row_len  [num_rows];
    logic  row_en   [num_rows];
    logic  row_conc [num_rows];
    logic  table_built = 1'b0;

    exp_word_t                             exp_q [ingress_pkg::num_ports][$];
    int                                    exp_cnt [ingress_pkg::num_ports];
    logic                                  mid_packet;
    logic [ingress_pkg::port_idx_bits-1:0] cur_port;
    logic [31:0]                           lcg_state;
    logic                                  bp_mode;
    int                                    mismatches = 0;
    int                                    other_errors = 0;

    router_ingress dut (.*);

    bind router_ingress router_ingress_assertions u_assertions (.*);

    initial begin
        core_clk_ifc = 1'b0;
        forever #50 core_clk_ifc = ~core_clk_ifc;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Table and expected values

    task automatic set_row(input int r, input string name, input int port, input int len,
                           input logic en, input logic conc);
        row_name[r] = name;
        row_port[r] = port;
        row_len[r]  = len;
        row_en[r]   = en;
        row_conc[r] = conc;
    endtask

    task automatic build_table();
        set_row(0,  "len1",      0, 1,  1'b1, 1'b0);
        set_row(1,  "len4",      1, 4,  1'b1, 1'b0);
        set_row(2,  "len5",      2, 5,  1'b1, 1'b0);
        set_row(3,  "len13",     0, 13, 1'b1, 1'b0);
        set_row(4,  "disabled",  1, 6,  1'b0, 1'b0);
        set_row(5,  "conc_p0",   0, 7,  1'b1, 1'b1);
        set_row(6,  "conc_p1",   1, 9,  1'b1, 1'b1);
        set_row(7,  "conc_p2",   2, 13, 1'b1, 1'b1);
        set_row(8,  "reenabled", 1, 3,  1'b1, 1'b0);
        set_row(9,  "bp_p0",     0, 13, 1'b1, 1'b1);
        set_row(10, "bp_p1",     1, 11, 1'b1, 1'b1);
        set_row(11, "bp_p2_off", 2, 2,  1'b0, 1'b1);
        set_row(12, "bp_p2",     2, 8,  1'b1, 1'b0);
        table_built = 1'b1;
    endtask

    function automatic int total_table_bytes();
        int n = 0;
        for (int r = 0; r < num_rows; r++) begin
            n += row_len[r];
        end
        return n;
    endfunction

    function automatic logic [7:0] row_byte(input int r, input int b);
        return 8'((r * 16 + b) % 256);
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Byte n of the packet goes to lane n mod 4 and keep marks the filled lanes
    task automatic push_expected(input int r);
        exp_word_t w;
        int        nwords;
        int        n;
        nwords = (row_len[r] + ingress_pkg::word_bytes - 1) / ingress_pkg::word_bytes;
        for (int i = 0; i < nwords; i++) begin
            w = '0;
            w.row = 8'(r);
            for (int b = 0; b < ingress_pkg::word_bytes; b++) begin
                n = i * ingress_pkg::word_bytes + b;
                if (n < row_len[r]) begin
                    w.data[8*b +: 8] = row_byte(r, n);
                    w.keep[b] = 1'b1;
                end
            end
            w.last = (i == nwords - 1);
            exp_q[row_port[r]].push_back(w);
        end
    endtask

    function automatic int pending_words();
        int n = 0;
        for (int p = 0; p < ingress_pkg::num_ports; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Drivers

    // Starts every row of the run in the same cycle from a falling edge
    task automatic send_run(input int first, input int last_row);
        int pos [ingress_pkg::num_ports];
        int rix [ingress_pkg::num_ports];
        int left;
        for (int p = 0; p < ingress_pkg::num_ports; p++) begin
            rix[p] = -1;
            pos[p] = 0;
        end
        for (int r = first; r <= last_row; r++) begin
            rix[row_port[r]] = r;
            port_enable[row_port[r]] = row_en[r];
            if (row_en[r]) begin
                push_expected(r);
                exp_cnt[row_port[r]]++;
            end
        end
        left = last_row - first + 1;
        while (left > 0) begin
            for (int p = 0; p < ingress_pkg::num_ports; p++) begin
                if (rix[p] >= 0 && pos[p] < row_len[rix[p]]) begin
                    in_valid[p] = 1'b1;
                    in_data[p]  = row_byte(rix[p], pos[p]);
                    in_last[p]  = (pos[p] == row_len[rix[p]] - 1);
                end else begin
                    in_valid[p] = 1'b0;
                    in_last[p]  = 1'b0;
                end
            end
            @(posedge core_clk_ifc);
            for (int p = 0; p < ingress_pkg::num_ports; p++) begin
                if (in_valid[p] && !row_en[rix[p]] && !in_ready[p]) begin
                    $display("ERROR: %s in_ready low on disabled port %0d", row_name[rix[p]], p);
                    other_errors++;
                end
                if (in_valid[p] && in_ready[p]) begin
                    pos[p]++;
                    if (pos[p] == row_len[rix[p]]) begin
                        left--;
                    end
                end
            end
            @(negedge core_clk_ifc);
        end
        in_valid = '0;
        in_last  = '0;
    endtask

    task automatic check_counts(input string name);
        for (int p = 0; p < ingress_pkg::num_ports; p++) begin
            if (frame_cnt[p] !== 16'(exp_cnt[p])) begin
                $display("MISMATCH %s frame_cnt[%0d] expected %0d actual %0d",
                         name, p, exp_cnt[p], frame_cnt[p]);
                mismatches++;
            end
        end
    endtask

    initial begin
        forever begin
            logic [31:0] rnd;
            @(negedge core_clk_ifc);
            rnd = lcg_next();
            out_ready = bp_mode ? rnd[16] : 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor

    task automatic check_out_word();
        exp_word_t e;
        int        p;
        p = int'(out_port);
        if (mid_packet && out_port != cur_port) begin
            $display("ERROR: word from port %0d interleaved into a packet from port %0d",
                     out_port, cur_port);
            other_errors++;
        end
        if (p >= ingress_pkg::num_ports || exp_q[p].size() == 0) begin
            $display("ERROR: unexpected word %h from port %0d", out_data, p);
            other_errors++;
        end else begin
            e = exp_q[p].pop_front();
            if (out_data !== e.data || out_keep !== e.keep || out_last !== e.last) begin
                $display("MISMATCH %s port %0d expected %h/%b/%b actual %h/%b/%b",
                         row_name[e.row], p, e.data, e.keep, e.last,
                         out_data, out_keep, out_last);
                mismatches++;
            end
        end
        mid_packet = !out_last;
        cur_port   = out_port;
    endtask

    always @(posedge core_clk_ifc) begin
        if (!reset && out_valid && out_ready) begin
            check_out_word();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequence

    initial begin
        int limit;
        wait (table_built);
        limit = 20 * total_table_bytes() + 200;
        for (int c = 0; c < limit; c++) begin
            @(posedge core_clk_ifc);
        end
        $display("Timeout: run did not complete within %0d clock cycles", limit);
        $display("Errors: %0d mismatches, %0d other errors", mismatches, other_errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int r;
        int last_row;
        reset       = 1'b1;
        in_valid    = '0;
        in_last     = '0;
        port_enable = '1;
        cnt_clear   = '0;
        out_ready   = 1'b1;
        bp_mode     = 1'b0;
        mid_packet  = 1'b0;
        cur_port    = '0;
        lcg_state   = 32'd31;
        for (int p = 0; p < ingress_pkg::num_ports; p++) begin
            in_data[p] = 8'h00;
            exp_cnt[p] = 0;
        end
        build_table();
        repeat (5) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        reset = 1'b0;
        if (out_valid !== 1'b0 || in_ready !== '1) begin
            $display("ERROR: bus not idle after reset");
            other_errors++;
        end
        check_counts("after_reset");

        r = 0;
        while (r < num_rows) begin
            if (r == bp_first) begin
                bp_mode = 1'b1;
            end
            last_row = r;
            // Group a run of concurrent rows
            while (row_conc[r] && last_row + 1 < num_rows && row_conc[last_row + 1]) begin
                last_row++;
            end
            send_run(r, last_row);
            while (pending_words() != 0) begin
                @(negedge core_clk_ifc);
            end
            check_counts(row_name[last_row]);
            r = last_row + 1;
        end
        bp_mode = 1'b0;

        // One-cycle clear on port 1 only
        cnt_clear[1] = 1'b1;
        @(negedge core_clk_ifc);
        cnt_clear  = '0;
        exp_cnt[1] = 0;
        check_counts("cnt_clear");

        $display("Errors: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
